//--- list.f
rtl/bpu_pkg.sv
rtl/bpu_decode_if.sv
rtl/bpu_update_if.sv
rtl/bpu_predecode.sv
rtl/bpu_bimodal.sv
rtl/bpu_btb.sv
rtl/bpu_ras.sv
rtl/bpu_next_pc.sv
rtl/bpu_top.sv
verif/tb_bpu.sv

//--- verif/tb_bpu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_bpu;

    // what the feedback side does in a row
    localparam int ACT_NONE       = 0;
    localparam int ACT_UPD_T      = 1;
    localparam int ACT_UPD_NT     = 2;
    localparam int ACT_PUSH       = 3;
    localparam int ACT_PUSH_STALL = 4;
    localparam int ACT_POP        = 5;
    localparam int ACT_POP_STALL  = 6;

    localparam bpu_pkg::addr_t NOP      = 32'h0000_0013;  // addi x0, x0, 0
    localparam bpu_pkg::addr_t RET_INST = 32'h0000_8067;  // jalr x0, 0(x1)
    localparam bpu_pkg::addr_t PC_NOP   = 32'h0000_1000;
    localparam bpu_pkg::addr_t PC_BR    = 32'h0000_2010;
    localparam bpu_pkg::addr_t PC_RET   = 32'h0000_6000;
    localparam bpu_pkg::addr_t RA_A     = 32'h0000_7004;
    localparam bpu_pkg::addr_t RA_B     = 32'h0000_8008;

    typedef struct packed {
        bpu_pkg::addr_t if_pc;
        bpu_pkg::addr_t if_inst;
        bpu_pkg::addr_t ex_pc;
        bpu_pkg::addr_t ex_target;
        bpu_pkg::addr_t ex_inst;
        bpu_pkg::addr_t push_addr;
        logic           ex_valid;
        logic           ex_taken;
        logic           push_valid;
        logic           ex_stall;
        logic           id_stall;
        logic           exp_br;
        logic           exp_tk;
        bpu_pkg::addr_t exp_pc;
    } row_t;

    logic           clk;
    logic           rst;
    bpu_pkg::addr_t if_pc;
    bpu_pkg::addr_t if_inst;
    bpu_pkg::addr_t ex_pc;
    bpu_pkg::addr_t ex_target;
    bpu_pkg::addr_t ex_inst;
    bpu_pkg::addr_t id_push_addr;
    logic           ex_valid;
    logic           ex_taken;
    logic           id_push_valid;
    logic           ex_stall;
    logic           id_stall;
    logic           branch;
    logic           pred_taken;
    bpu_pkg::addr_t pred_pc;

    row_t           rows[$];
    int             wait_cycles;
    int unsigned    seed_ret;

    bpu_top i_dut (
        .clk             (clk),
        .rst             (rst),
        .if_pc_i         (if_pc),
        .if_inst_i       (if_inst),
        .ex_pc_i         (ex_pc),
        .ex_target_i     (ex_target),
        .ex_inst_i       (ex_inst),
        .id_push_addr_i  (id_push_addr),
        .ex_valid_i      (ex_valid),
        .ex_taken_i      (ex_taken),
        .id_push_valid_i (id_push_valid),
        .ex_stall_i      (ex_stall),
        .id_stall_i      (id_stall),
        .branch_o        (branch),
        .pred_taken_o    (pred_taken),
        .pred_pc_o       (pred_pc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
    end

    // beq with random source registers
    function automatic bpu_pkg::addr_t enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'($urandom), 5'($urandom), 3'b000,
                imm[4:1], imm[11], bpu_pkg::OPC_BRANCH};
    endfunction

    function automatic bpu_pkg::addr_t enc_jal(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, bpu_pkg::OPC_JAL};
    endfunction

    function automatic bpu_pkg::addr_t enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                                input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, bpu_pkg::OPC_JALR};
    endfunction

    task automatic add_row(input int act, input bpu_pkg::addr_t pc, input bpu_pkg::addr_t inst,
                           input bpu_pkg::addr_t a, input bpu_pkg::addr_t b,
                           input logic br, input logic tk, input bpu_pkg::addr_t npc);
        row_t r;
        r.if_pc      = pc;
        r.if_inst    = inst;
        r.ex_valid   = 1'b0;
        r.ex_taken   = 1'($urandom);  // unused fields get random fill
        r.ex_pc      = $urandom;
        r.ex_target  = $urandom;
        r.ex_inst    = $urandom;
        r.push_valid = 1'b0;
        r.push_addr  = $urandom;
        r.ex_stall   = 1'($urandom);
        r.id_stall   = 1'($urandom);
        if (act == ACT_UPD_T || act == ACT_UPD_NT) begin
            r.ex_valid  = 1'b1;
            r.ex_taken  = (act == ACT_UPD_T);
            r.ex_pc     = a;
            r.ex_target = b;
            r.ex_inst   = enc_branch(13'h010);
        end else if (act == ACT_PUSH || act == ACT_PUSH_STALL) begin
            r.push_valid = 1'b1;
            r.push_addr  = a;
            r.ex_stall   = 1'b0;
            r.id_stall   = (act == ACT_PUSH_STALL);
        end else if (act == ACT_POP || act == ACT_POP_STALL) begin
            r.ex_valid  = 1'b1;
            r.ex_taken  = 1'b1;
            r.ex_pc     = a;
            r.ex_target = b;
            r.ex_inst   = RET_INST;
            r.ex_stall  = (act == ACT_POP_STALL);
        end
        r.exp_br = br;
        r.exp_tk = tk;
        r.exp_pc = npc;
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        if_pc         = r.if_pc;
        if_inst       = r.if_inst;
        ex_pc         = r.ex_pc;
        ex_target     = r.ex_target;
        ex_inst       = r.ex_inst;
        ex_valid      = r.ex_valid;
        ex_taken      = r.ex_taken;
        id_push_valid = r.push_valid;
        id_push_addr  = r.push_addr;
        ex_stall      = r.ex_stall;
        id_stall      = r.id_stall;
    endtask

    task automatic check_bit(input string what, input int row, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: row %0d %s is %b, expected %b", $time, row, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_addr(input string what, input int row, input bpu_pkg::addr_t got,
                              input bpu_pkg::addr_t exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: row %0d %s is %h, expected %h", $time, row, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "address mismatch");
        end
    endtask

    initial begin
        if_pc         = '0;
        if_inst       = NOP;
        ex_pc         = '0;
        ex_target     = '0;
        ex_inst       = '0;
        id_push_addr  = '0;
        ex_valid      = 1'b0;
        ex_taken      = 1'b0;
        id_push_valid = 1'b0;
        ex_stall      = 1'b0;
        id_stall      = 1'b0;
        seed_ret      = $urandom(32'haedc);

        // cold state after reset
        add_row(ACT_NONE, PC_NOP, NOP, 0, 0, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_NONE, PC_BR, enc_branch(13'h040), 0, 0, 1'b1, 1'b0, PC_BR + 4);
        add_row(ACT_NONE, 32'h3000, enc_jal(21'h00100, 5'd1), 0, 0, 1'b1, 1'b1, 32'h3100);
        add_row(ACT_NONE, 32'h3000, enc_jal(21'h1fffe0, 5'd0), 0, 0, 1'b1, 1'b1, 32'h2fe0);
        // counter at PC_BR walks 01 10 11 11 11 10 01 00
        add_row(ACT_UPD_T, PC_BR, enc_branch(13'h040), PC_BR, PC_BR + 32'h40, 1'b1, 1'b0,
                PC_BR + 4);
        add_row(ACT_UPD_T, PC_BR, enc_branch(13'h040), PC_BR, PC_BR + 32'h40, 1'b1, 1'b1,
                PC_BR + 32'h40);
        add_row(ACT_UPD_T, PC_BR, enc_branch(13'h040), PC_BR, PC_BR + 32'h40, 1'b1, 1'b1,
                PC_BR + 32'h40);
        add_row(ACT_UPD_T, PC_BR, enc_branch(13'h040), PC_BR, PC_BR + 32'h40, 1'b1, 1'b1,
                PC_BR + 32'h40);
        add_row(ACT_UPD_NT, PC_BR, enc_branch(13'h040), PC_BR, 0, 1'b1, 1'b1, PC_BR + 32'h40);
        add_row(ACT_NONE, PC_BR, enc_branch(13'h040), 0, 0, 1'b1, 1'b1, PC_BR + 32'h40);
        add_row(ACT_UPD_NT, PC_BR, enc_branch(13'h040), PC_BR, 0, 1'b1, 1'b1, PC_BR + 32'h40);
        add_row(ACT_UPD_NT, PC_BR, enc_branch(13'h040), PC_BR, 0, 1'b1, 1'b0, PC_BR + 4);
        add_row(ACT_NONE, PC_BR, enc_branch(13'h040), 0, 0, 1'b1, 1'b0, PC_BR + 4);
        // btb fill, then an alias with the same index bits and another tag
        add_row(ACT_UPD_T, PC_NOP, NOP, 32'h4020, 32'h5678, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_NONE, 32'h4020, enc_branch(13'h080), 0, 0, 1'b1, 1'b1, 32'h5678);
        add_row(ACT_NONE, 32'h4020, enc_jal(21'h00200, 5'd0), 0, 0, 1'b1, 1'b1, 32'h5678);
        add_row(ACT_NONE, 32'h4420, enc_branch(13'h080), 0, 0, 1'b1, 1'b1, 32'h44a0);
        add_row(ACT_NONE, 32'h4420, enc_jal(21'h00200, 5'd0), 0, 0, 1'b1, 1'b1, 32'h4620);
        // return stack
        add_row(ACT_NONE, PC_RET, RET_INST, 0, 0, 1'b1, 1'b0, PC_RET + 4);
        add_row(ACT_PUSH, PC_NOP, NOP, RA_A, 0, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_PUSH, PC_NOP, NOP, RA_B, 0, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_NONE, PC_RET, RET_INST, 0, 0, 1'b1, 1'b1, RA_B);
        add_row(ACT_POP, PC_NOP, NOP, 32'h9000, 32'h9100, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_NONE, PC_RET, RET_INST, 0, 0, 1'b1, 1'b1, RA_A);
        add_row(ACT_POP, PC_NOP, NOP, 32'h9000, 32'h9100, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_NONE, PC_RET, RET_INST, 0, 0, 1'b1, 1'b0, PC_RET + 4);
        add_row(ACT_PUSH_STALL, PC_NOP, NOP, RA_A, 0, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_NONE, PC_RET, RET_INST, 0, 0, 1'b1, 1'b0, PC_RET + 4);
        add_row(ACT_PUSH, PC_NOP, NOP, RA_A, 0, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_POP_STALL, PC_NOP, NOP, 32'h9000, 32'h9100, 1'b0, 1'b0, PC_NOP + 4);
        add_row(ACT_NONE, PC_RET, RET_INST, 0, 0, 1'b1, 1'b1, RA_A);
        // bypass from decode, then a return racing an execute pop
        add_row(ACT_PUSH, PC_RET, RET_INST, RA_B, 0, 1'b1, 1'b1, RA_B);
        add_row(ACT_POP, PC_RET, RET_INST, 32'h9000, 32'h9100, 1'b1, 1'b0, PC_RET + 4);
        add_row(ACT_NONE, PC_RET, RET_INST, 0, 0, 1'b1, 1'b1, RA_A);
        // register jumps, only the last is a return
        add_row(ACT_NONE, 32'h6100, enc_jalr(5'd1, 5'd10, 12'h000), 0, 0, 1'b1, 1'b0, 32'h6104);
        add_row(ACT_NONE, 32'h6200, enc_jalr(5'd0, 5'd1, 12'h004), 0, 0, 1'b1, 1'b0, 32'h6204);
        add_row(ACT_NONE, 32'h6300, enc_jalr(5'd0, 5'd5, 12'h000), 0, 0, 1'b1, 1'b1, RA_A);

        wait_cycles = 0;
        while (rst !== 1'b0 && wait_cycles < 20) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (rst !== 1'b0) begin
            $display("reset was not released within 20 cycles");
            $display("TEST RESULT: FAIL");
            $fatal(1, "reset timeout");
        end

        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            drive_row(rows[i]);
            #2;  // outputs settled, next edge still 1 ns away
            check_bit("branch_o", i, branch, rows[i].exp_br);
            check_bit("pred_taken_o", i, pred_taken, rows[i].exp_tk);
            check_addr("pred_pc_o", i, pred_pc, rows[i].exp_pc);
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/bpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_top #(
    parameter int BIMODAL_ENTRIES = 512,
    parameter int BTB_ENTRIES     = 256,
    parameter int RAS_DEPTH       = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  bpu_pkg::addr_t  if_pc_i,
    input  bpu_pkg::addr_t  if_inst_i,
    input  bpu_pkg::addr_t  ex_pc_i,
    input  bpu_pkg::addr_t  ex_target_i,
    input  bpu_pkg::addr_t  ex_inst_i,
    input  bpu_pkg::addr_t  id_push_addr_i,
    input  logic            ex_valid_i,
    input  logic            ex_taken_i,
    input  logic            id_push_valid_i,
    input  logic            ex_stall_i,
    input  logic            id_stall_i,
    output logic            branch_o,
    output logic            pred_taken_o,
    output bpu_pkg::addr_t  pred_pc_o
);

    bpu_decode_if dec_if ();
    bpu_update_if upd_if ();

    logic           dir_taken;
    logic           btb_hit;
    bpu_pkg::addr_t btb_target;
    logic           ras_pop_now;
    logic           ras_nonempty;
    bpu_pkg::addr_t ras_top;

    bpu_predecode i_predecode (
        .if_pc_i         (if_pc_i),
        .if_inst_i       (if_inst_i),
        .ex_inst_i       (ex_inst_i),
        .ex_pc_i         (ex_pc_i),
        .ex_target_i     (ex_target_i),
        .ex_valid_i      (ex_valid_i),
        .ex_taken_i      (ex_taken_i),
        .ex_stall_i      (ex_stall_i),
        .id_stall_i      (id_stall_i),
        .id_push_valid_i (id_push_valid_i),
        .id_push_addr_i  (id_push_addr_i),
        .dec_o           (dec_if.src),
        .upd_o           (upd_if.src)
    );

    bpu_bimodal #(
        .BIMODAL_ENTRIES (BIMODAL_ENTRIES)
    ) i_bimodal (
        .clk         (clk),
        .rst         (rst),
        .dec_i       (dec_if.dst),
        .upd_i       (upd_if.tbl),
        .dir_taken_o (dir_taken)
    );

    bpu_btb #(
        .BTB_ENTRIES (BTB_ENTRIES)
    ) i_btb (
        .clk      (clk),
        .rst      (rst),
        .dec_i    (dec_if.dst),
        .upd_i    (upd_if.tbl),
        .hit_o    (btb_hit),
        .target_o (btb_target)
    );

    bpu_ras #(
        .RAS_DEPTH (RAS_DEPTH)
    ) i_ras (
        .clk        (clk),
        .rst        (rst),
        .upd_i      (upd_if.tbl),
        .pop_now_o  (ras_pop_now),
        .nonempty_o (ras_nonempty),
        .top_o      (ras_top)
    );

    // bypass uses the ungated decode push
    bpu_next_pc i_next_pc (
        .dec_i          (dec_if.dst),
        .dir_taken_i    (dir_taken),
        .btb_hit_i      (btb_hit),
        .ras_pop_now_i  (ras_pop_now),
        .ras_nonempty_i (ras_nonempty),
        .btb_target_i   (btb_target),
        .ras_top_i      (ras_top),
        .push_valid_i   (upd_if.push_valid),
        .push_addr_i    (upd_if.push_addr),
        .branch_o       (branch_o),
        .pred_taken_o   (pred_taken_o),
        .pred_pc_o      (pred_pc_o)
    );

endmodule

`default_nettype wire

//--- rtl/bpu_next_pc.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_next_pc (
    bpu_decode_if.dst       dec_i,
    input  logic            dir_taken_i,
    input  logic            btb_hit_i,
    input  logic            ras_pop_now_i,
    input  logic            ras_nonempty_i,
    input  bpu_pkg::addr_t  btb_target_i,
    input  bpu_pkg::addr_t  ras_top_i,
    input  logic            push_valid_i,
    input  bpu_pkg::addr_t  push_addr_i,
    output logic            branch_o,
    output logic            pred_taken_o,
    output bpu_pkg::addr_t  pred_pc_o
);

    assign branch_o = dec_i.is_branch || dec_i.is_jal || dec_i.is_jalr;

    always_comb begin
        pred_taken_o = 1'b0;
        pred_pc_o    = dec_i.seq_pc;
        if (dec_i.is_ret) begin
            if (ras_pop_now_i) begin
                pred_taken_o = 1'b0;  // stack top is about to change
            end else if (push_valid_i) begin
                pred_taken_o = 1'b1;  // call in decode this cycle
                pred_pc_o    = push_addr_i;
            end else if (ras_nonempty_i) begin
                pred_taken_o = 1'b1;
                pred_pc_o    = ras_top_i;
            end
        end else if (dec_i.is_jal) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit_i ? btb_target_i : dec_i.jal_target;
        end else if (dec_i.is_jalr) begin
            // indirect target unknown here
            pred_taken_o = 1'b0;
        end else if (dec_i.is_branch && dir_taken_i) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = btb_hit_i ? btb_target_i : dec_i.br_target;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpu_ras.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_ras #(
    parameter int RAS_DEPTH = 64
) (
    input  logic            clk,
    input  logic            rst,
    bpu_update_if.tbl       upd_i,
    output logic            pop_now_o,
    output logic            nonempty_o,
    output bpu_pkg::addr_t  top_o
);

    localparam int IDX_W = $clog2(RAS_DEPTH);
    localparam int PTR_W = IDX_W + 1;  // extra bit so full is representable

    bpu_pkg::addr_t   stack_q [RAS_DEPTH];
    logic [PTR_W-1:0] sp_q;           // next free slot
    logic [PTR_W-1:0] sp_dec;
    logic [PTR_W-1:0] sp_after_pop;
    logic             do_pop;
    logic             do_push;

    assign sp_dec = sp_q - 1'b1;

    assign nonempty_o = (sp_q != '0);
    assign top_o      = stack_q[sp_dec[IDX_W-1:0]];
    assign pop_now_o  = upd_i.pop_en;

    // pop goes first, push then lands on the new top
    assign do_pop       = upd_i.pop_en && nonempty_o;
    assign sp_after_pop = do_pop ? sp_dec : sp_q;
    assign do_push      = upd_i.push_en && (sp_after_pop != PTR_W'(RAS_DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sp_q <= '0;
        end else if (do_push) begin
            sp_q <= sp_after_pop + 1'b1;
        end else begin
            sp_q <= sp_after_pop;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[sp_after_pop[IDX_W-1:0]] <= upd_i.push_addr;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpu_btb.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_btb #(
    parameter int BTB_ENTRIES = 256
) (
    input  logic            clk,
    input  logic            rst,
    bpu_decode_if.dst       dec_i,
    bpu_update_if.tbl       upd_i,
    output logic            hit_o,
    output bpu_pkg::addr_t  target_o
);

    localparam int IDX_W = $clog2(BTB_ENTRIES);
    localparam int TAG_W = bpu_pkg::XLEN - IDX_W - 2;

    logic             valid_q  [BTB_ENTRIES];
    logic [TAG_W-1:0] tag_q    [BTB_ENTRIES];
    bpu_pkg::addr_t   target_q [BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_en;

    // word aligned index, everything above is tag
    assign rd_idx = dec_i.fetch_pc[IDX_W+1:2];
    assign rd_tag = dec_i.fetch_pc[bpu_pkg::XLEN-1:IDX_W+2];
    assign wr_idx = upd_i.upd_pc[IDX_W+1:2];
    assign wr_tag = upd_i.upd_pc[bpu_pkg::XLEN-1:IDX_W+2];

    assign wr_en = upd_i.upd_valid && upd_i.upd_taken;

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd_i.upd_target;
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpu_bimodal.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_bimodal #(
    parameter int BIMODAL_ENTRIES = 512
) (
    input  logic         clk,
    input  logic         rst,
    bpu_decode_if.dst    dec_i,
    bpu_update_if.tbl    upd_i,
    output logic         dir_taken_o
);

    localparam int IDX_W = $clog2(BIMODAL_ENTRIES);

    bpu_pkg::ctr_t    ctr_q [BIMODAL_ENTRIES];
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] upd_idx;
    bpu_pkg::ctr_t    upd_cur;
    bpu_pkg::ctr_t    upd_next;

    // halfword granularity, bit 0 skipped
    assign rd_idx  = dec_i.fetch_pc[IDX_W:1];
    assign upd_idx = upd_i.upd_pc[IDX_W:1];

    assign dir_taken_o = ctr_q[rd_idx][1];

    assign upd_cur = ctr_q[upd_idx];

    always_comb begin
        upd_next = upd_cur;
        if (upd_i.upd_taken) begin
            if (upd_cur != 2'b11) begin
                upd_next = upd_cur + 2'b01;
            end
        end else if (upd_cur != 2'b00) begin
            upd_next = upd_cur - 2'b01;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BIMODAL_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::CTR_INIT;
            end
        end else if (upd_i.upd_valid) begin
            ctr_q[upd_idx] <= upd_next;  // trained on every resolved branch
        end
    end

endmodule

`default_nettype wire

//--- rtl/bpu_predecode.sv
`timescale 1ns/1ns
`default_nettype none

module bpu_predecode (
    input  bpu_pkg::addr_t   if_pc_i,
    input  bpu_pkg::addr_t   if_inst_i,
    input  bpu_pkg::addr_t   ex_inst_i,
    input  bpu_pkg::addr_t   ex_pc_i,
    input  bpu_pkg::addr_t   ex_target_i,
    input  logic             ex_valid_i,
    input  logic             ex_taken_i,
    input  logic             ex_stall_i,
    input  logic             id_stall_i,
    input  logic             id_push_valid_i,
    input  bpu_pkg::addr_t   id_push_addr_i,
    bpu_decode_if.src        dec_o,
    bpu_update_if.src        upd_o
);

    bpu_pkg::inst_u  if_word;
    bpu_pkg::inst_u  ex_word;
    bpu_pkg::addr_t  b_imm;
    bpu_pkg::addr_t  j_imm;
    logic            if_link_src;
    logic            ex_link_src;

    assign if_word = if_inst_i;
    assign ex_word = ex_inst_i;

    // sign-extended immediates, bit 0 always zero
    assign b_imm = {{20{if_word.b_view.imm12}}, if_word.b_view.imm11,
                    if_word.b_view.imm10_5, if_word.b_view.imm4_1, 1'b0};
    assign j_imm = {{12{if_word.j_view.imm20}}, if_word.j_view.imm19_12,
                    if_word.j_view.imm11, if_word.j_view.imm10_1, 1'b0};

    assign if_link_src = (if_word.i_view.rs1 == bpu_pkg::RA_REG) ||
                         (if_word.i_view.rs1 == bpu_pkg::ALT_LINK_REG);
    assign ex_link_src = (ex_word.i_view.rs1 == bpu_pkg::RA_REG) ||
                         (ex_word.i_view.rs1 == bpu_pkg::ALT_LINK_REG);

    assign dec_o.fetch_pc   = if_pc_i;
    assign dec_o.is_branch  = (if_word.b_view.opcode == bpu_pkg::OPC_BRANCH);
    assign dec_o.is_jal     = (if_word.j_view.opcode == bpu_pkg::OPC_JAL);
    assign dec_o.is_jalr    = (if_word.i_view.opcode == bpu_pkg::OPC_JALR);
    assign dec_o.is_ret     = dec_o.is_jalr && (if_word.i_view.rd == 5'd0) &&
                              if_link_src && (if_word.i_view.imm == 12'd0);
    assign dec_o.br_target  = if_pc_i + b_imm;
    assign dec_o.jal_target = if_pc_i + j_imm;
    assign dec_o.seq_pc     = if_pc_i + 32'd4;

    assign upd_o.upd_valid  = ex_valid_i;
    assign upd_o.upd_taken  = ex_taken_i;
    assign upd_o.upd_pc     = ex_pc_i;
    assign upd_o.upd_target = ex_target_i;
    // rd is not checked on the execute side
    assign upd_o.ex_ret     = (ex_word.i_view.opcode == bpu_pkg::OPC_JALR) &&
                              ex_link_src && (ex_word.i_view.imm == 12'd0);
    assign upd_o.push_valid = id_push_valid_i;
    assign upd_o.push_addr  = id_push_addr_i;

    // the only place the stall gating lives
    assign upd_o.pop_en  = upd_o.upd_valid && upd_o.upd_taken && upd_o.ex_ret && !ex_stall_i;
    assign upd_o.push_en = id_push_valid_i && !ex_stall_i && !id_stall_i;

endmodule

`default_nettype wire

//--- rtl/bpu_update_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bpu_update_if;

    logic           upd_valid;
    logic           upd_taken;
    bpu_pkg::addr_t upd_pc;
    bpu_pkg::addr_t upd_target;
    logic           ex_ret;      // execute word is a return
    logic           push_valid;  // call seen in decode, ungated
    bpu_pkg::addr_t push_addr;
    logic           pop_en;
    logic           push_en;

    modport src (
        output upd_valid, upd_taken, upd_pc, upd_target, ex_ret,
        output push_valid, push_addr, pop_en, push_en
    );

    modport tbl (
        input upd_valid, upd_taken, upd_pc, upd_target, ex_ret,
        input push_valid, push_addr, pop_en, push_en
    );

endinterface

`default_nettype wire

//--- rtl/bpu_decode_if.sv
`timescale 1ns/1ns
`default_nettype none

interface bpu_decode_if;

    bpu_pkg::addr_t fetch_pc;
    logic           is_branch;
    logic           is_jal;
    logic           is_jalr;
    logic           is_ret;
    bpu_pkg::addr_t br_target;   // pc + b immediate
    bpu_pkg::addr_t jal_target;  // pc + j immediate
    bpu_pkg::addr_t seq_pc;      // pc + 4

    modport src (
        output fetch_pc, is_branch, is_jal, is_jalr, is_ret,
        output br_target, jal_target, seq_pc
    );

    modport dst (
        input fetch_pc, is_branch, is_jal, is_jalr, is_ret,
        input br_target, jal_target, seq_pc
    );

endinterface

`default_nettype wire

//--- rtl/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [1:0]      ctr_t;  // msb set means taken

    localparam ctr_t CTR_INIT = 2'b01;  // weakly not-taken

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // link registers that mark a return
    localparam logic [4:0] RA_REG       = 5'd1;
    localparam logic [4:0] ALT_LINK_REG = 5'd5;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_view_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    // one instruction word, three decodings
    typedef union packed {
        b_view_t b_view;
        j_view_t j_view;
        i_view_t i_view;
    } inst_u;

endpackage

`default_nettype wire
